// File: filelist.f
copro_pkg.sv
tube_pkg.sv
int_ram.sv
ext_mem_ctrl.sv
tube_regs.sv
copro_bus.sv
tb_sram_model.sv
tb_copro.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the copro_bus testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tb_copro \
   --Mdir obj_dir -o tb_copro_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/tb_copro_sim
status=$?
if [ $status -ne 0 ]; then
   echo "simulation failed with status $status"
   exit $status
fi

exit 0

// File: tb_copro.sv
`default_nettype none

module tb_copro;

   localparam int NUM_TXN    = 300;
   localparam int POOL       = 8;
   // worst access is 3 bus cycles plus 2 idle cycles, warm-up and reset on top
   localparam int MAX_CYCLES = (NUM_TXN + 2 * POOL + 2) * 6 + 50;

   logic                            cpu_clk;
   logic                            reset;
   logic [copro_pkg::ASIZE-1:0]     cpu_addr;
   logic [copro_pkg::DSIZE-1:0]     cpu_dout;
   logic                            cpu_rnw;
   logic                            vpa;
   logic                            vda;
   logic                            vio;
   wire  [copro_pkg::DSIZE-1:0]     cpu_din;
   wire                             cpu_clken;
   wire                             cpu_irq_b;
   logic [tube_pkg::TUBE_AW-1:0]    h_addr;
   logic                            h_cs_b;
   logic                            h_rdnw;
   logic [tube_pkg::TUBE_DW-1:0]    h_din;
   wire  [tube_pkg::TUBE_DW-1:0]    h_dout;
   wire                             h_irq_b;
   wire  [copro_pkg::EXT_ASIZE-1:0] ram_addr;
   wire  [7:0]                      ram_dout;
   wire  [7:0]                      ram_din;
   wire                             ram_cs_b;
   wire                             ram_oe_b;
   wire                             ram_we_b;

   // --------------------------------------------------
   // reference model state
   // --------------------------------------------------

   // address pools, small so data gets re-read
   logic [15:0] int_pool_addr [0:POOL-1];
   logic [15:0] int_pool_data [0:POOL-1];
   logic [15:0] ext_pool_addr [0:POOL-1];
   logic [15:0] ext_pool_data [0:POOL-1];
   // mailbox latches and control
   logic [7:0]  h2p_byte;
   logic [7:0]  p2h_byte;
   logic        h2p_full;
   logic        p2h_full;
   logic        irq_en;
   integer      seed = 88;
   integer      cycles = 0;

   copro_bus u_dut (
      .cpu_clk   (cpu_clk),
      .reset     (reset),
      .cpu_addr  (cpu_addr),
      .cpu_dout  (cpu_dout),
      .cpu_rnw   (cpu_rnw),
      .vpa       (vpa),
      .vda       (vda),
      .vio       (vio),
      .cpu_din   (cpu_din),
      .cpu_clken (cpu_clken),
      .cpu_irq_b (cpu_irq_b),
      .h_addr    (h_addr),
      .h_cs_b    (h_cs_b),
      .h_rdnw    (h_rdnw),
      .h_din     (h_din),
      .h_dout    (h_dout),
      .h_irq_b   (h_irq_b),
      .ram_addr  (ram_addr),
      .ram_dout  (ram_dout),
      .ram_din   (ram_din),
      .ram_cs_b  (ram_cs_b),
      .ram_oe_b  (ram_oe_b),
      .ram_we_b  (ram_we_b)
   );

   tb_sram_model u_sram (
      .cpu_clk  (cpu_clk),
      .ram_addr (ram_addr),
      .ram_dout (ram_dout),
      .ram_din  (ram_din),
      .ram_cs_b (ram_cs_b),
      .ram_oe_b (ram_oe_b),
      .ram_we_b (ram_we_b)
   );

   always #4 cpu_clk = ~cpu_clk;

   // runaway guard
   always @(posedge cpu_clk)
   begin
      cycles <= cycles + 1;
      if (cycles > MAX_CYCLES)
      begin
         $display("Test failed");
         $fatal(1, "timeout, the run went past %0d cycles without finishing", MAX_CYCLES);
      end
   end

   // --------------------------------------------------
   // helpers
   // --------------------------------------------------

   task automatic check(input string name, input logic [15:0] expected,
                        input logic [15:0] actual);
      if (expected !== actual)
      begin
         $display("Mismatch in test %s: expected %h, actual %h", name, expected, actual);
         $display("Test failed");
         $fatal(1, "stopped at the first wrong value");
      end
   endtask

   function automatic logic [31:0] next_rand();
      return $random(seed);
   endfunction

   function automatic logic [15:0] rand_word();
      logic [31:0] r;
      r = $random(seed);
      return r[15:0];
   endfunction

   // cpu access held until clken seen high, sampled on the falling edge
   task automatic cpu_access(input logic [15:0] addr, input logic [15:0] wdata,
                             input logic rnw, input logic io,
                             output logic [15:0] data, output int stalls);
      logic [31:0] r;
      r = next_rand();
      @(posedge cpu_clk);
      cpu_addr <= addr;
      cpu_dout <= wdata;
      cpu_rnw  <= rnw;
      vio      <= io;
      // memory cycles as opcode fetch, data or both
      vpa      <= !io && r[0];
      vda      <= !io && (r[1] || !r[0]);
      stalls = 0;
      @(negedge cpu_clk);
      while (!cpu_clken)
      begin
         stalls++;
         @(negedge cpu_clk);
      end
      data = cpu_din;
   endtask

   // host strobe for one cycle
   task automatic host_access(input logic [2:0] addr, input logic [7:0] wdata,
                              input logic rdnw, output logic [7:0] data);
      @(posedge cpu_clk);
      h_cs_b <= 1'b0;
      h_addr <= addr;
      h_rdnw <= rdnw;
      h_din  <= wdata;
      @(negedge cpu_clk);
      data = h_dout;
   endtask

   // completing edge, then one more edge for the irq flop
   task automatic idle_check_irq();
      @(posedge cpu_clk);
      vpa    <= 1'b0;
      vda    <= 1'b0;
      vio    <= 1'b0;
      h_cs_b <= 1'b1;
      @(posedge cpu_clk);
      @(negedge cpu_clk);
      check("cpu irq", 16'(!(h2p_full && irq_en)), 16'(cpu_irq_b));
   endtask

   // --------------------------------------------------
   // transactions
   // --------------------------------------------------

   task automatic mem_txn(input logic ext, input int i, input logic rnw);
      logic [15:0] wdata;
      logic [15:0] data;
      logic [16:0] byte_addr;
      int          stalls;
      wdata = rand_word();
      if (ext)
      begin
         cpu_access(ext_pool_addr[i], wdata, rnw, 1'b0, data, stalls);
         // two byte cycles before the word completes
         check("external stall", 16'd2, 16'(stalls));
         if (rnw)
            check("external read", ext_pool_data[i], data);
         else
         begin
            ext_pool_data[i] = wdata;
            // window starts at 1000, low byte at the even sram address
            byte_addr = {ext_pool_addr[i] - 16'h1000, 1'b0};
            check("external low byte", {8'h00, wdata[7:0]},
                  {8'h00, u_sram.mem[byte_addr]});
            check("external high byte", {8'h00, wdata[15:8]},
                  {8'h00, u_sram.mem[byte_addr + 17'd1]});
         end
      end
      else
      begin
         cpu_access(int_pool_addr[i], wdata, rnw, 1'b0, data, stalls);
         check("internal stall", 16'd0, 16'(stalls));
         if (rnw)
            check("internal read", int_pool_data[i], data);
         else
            int_pool_data[i] = wdata;
      end
      idle_check_irq();
   endtask

   task automatic par_read(input logic [2:0] k);
      logic [15:0] data;
      int          stalls;
      cpu_access({copro_pkg::TUBE_BASE[15:3], k}, rand_word(), 1'b1, 1'b1, data, stalls);
      check("parasite tube stall", 16'd0, 16'(stalls));
      case (k)
         3'd0: check("parasite status", {8'h00, h2p_full, !p2h_full, 6'b0}, data);
         3'd1:
         begin
            if (h2p_full)
               check("parasite data", {8'h00, h2p_byte}, data);
            h2p_full = 1'b0;
         end
         3'd2: check("parasite ctrl", {15'd0, irq_en}, data);
         default: check("parasite unused reg", 16'd0, data);
      endcase
      idle_check_irq();
   endtask

   task automatic par_write();
      logic [15:0] wdata;
      logic [15:0] data;
      int          stalls;
      wdata = rand_word();
      cpu_access({copro_pkg::TUBE_BASE[15:3], 3'd1}, wdata, 1'b0, 1'b1, data, stalls);
      check("parasite tube stall", 16'd0, 16'(stalls));
      // full latch drops the byte
      if (!p2h_full)
      begin
         p2h_byte = wdata[7:0];
         p2h_full = 1'b1;
      end
      idle_check_irq();
   endtask

   task automatic host_read(input logic [2:0] k);
      logic [7:0] data;
      host_access(k, 8'h00, 1'b1, data);
      case (k)
         3'd0: check("host status", {8'h00, p2h_full, !h2p_full, 6'b0}, {8'h00, data});
         3'd1:
         begin
            if (p2h_full)
               check("host data", {8'h00, p2h_byte}, {8'h00, data});
            p2h_full = 1'b0;
         end
         3'd2: check("host ctrl", {15'd0, irq_en}, {8'h00, data});
         default: check("host unused reg", 16'd0, {8'h00, data});
      endcase
      idle_check_irq();
   endtask

   task automatic host_write(input logic [2:0] k);
      logic [15:0] w;
      logic [7:0]  data;
      w = rand_word();
      host_access(k, w[7:0], 1'b0, data);
      if (k == 3'd1 && !h2p_full)
      begin
         h2p_byte = w[7:0];
         h2p_full = 1'b1;
      end
      else if (k == 3'd2)
         irq_en = w[0];
      idle_check_irq();
   endtask

   // --------------------------------------------------
   // main sequence
   // --------------------------------------------------

   initial
   begin
      logic [31:0] r;
      logic [2:0]  k;
      int          idx;
      cpu_clk  = 1'b0;
      reset    = 1'b1;
      cpu_addr = '0;
      cpu_dout = '0;
      cpu_rnw  = 1'b1;
      vpa      = 1'b0;
      vda      = 1'b0;
      vio      = 1'b0;
      h_addr   = '0;
      h_cs_b   = 1'b1;
      h_rdnw   = 1'b1;
      h_din    = '0;
      h2p_byte = '0;
      p2h_byte = '0;
      h2p_full = 1'b0;
      p2h_full = 1'b0;
      irq_en   = 1'b0;

      // unique pool entries, half in each internal window
      for (int i = 0; i < POOL; i++)
      begin
         r = next_rand();
         int_pool_addr[i] = {(i[2] ? 4'hF : 4'h0), 2'(i), r[9:0]};
         ext_pool_addr[i] = {4'(i + 1), r[21:10]};
      end

      repeat (2) @(posedge cpu_clk);
      reset <= 1'b0;
      @(negedge cpu_clk);
      check("reset clken", 16'd1, 16'(cpu_clken));
      check("reset ram cs", 16'd1, 16'(ram_cs_b));
      check("reset ram oe", 16'd1, 16'(ram_oe_b));
      check("reset ram we", 16'd1, 16'(ram_we_b));
      check("reset cpu irq", 16'd1, 16'(cpu_irq_b));
      check("reset host irq", 16'd1, 16'(h_irq_b));
      // both sides see empty latches
      par_read(3'd0);
      host_read(3'd0);

      // every pool word gets a known value
      for (int i = 0; i < POOL; i++)
      begin
         mem_txn(1'b0, i, 1'b0);
         mem_txn(1'b1, i, 1'b0);
      end

      repeat (NUM_TXN)
      begin
         r   = next_rand();
         idx = int'(r[10:8]) % POOL;
         k   = (r[13:12] == 2'd3) ? 3'(3 + r[15:14]) : 3'(r[13:12]);
         case (r[7:0] % 12)
            0:       mem_txn(1'b0, idx, 1'b1);
            1:       mem_txn(1'b0, idx, 1'b0);
            2:       mem_txn(1'b1, idx, 1'b1);
            3:       mem_txn(1'b1, idx, 1'b0);
            4:       par_read(k);
            5:       par_read(3'd1);
            6:       par_write();
            7:       host_read(k);
            8:       host_read(3'd1);
            9:       host_write(3'd1);
            10:      host_write(3'd2);
            default: mem_txn(1'b1, idx, 1'b1);
         endcase
      end

      $display("Test passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: tb_sram_model.sv
`default_nettype none

module tb_sram_model (
   input  wire                             cpu_clk,
   input  wire  [copro_pkg::EXT_ASIZE-1:0] ram_addr,
   input  wire  [7:0]                      ram_dout,
   output logic [7:0]                      ram_din,
   input  wire                             ram_cs_b,
   input  wire                             ram_oe_b,
   input  wire                             ram_we_b
);

   localparam int DEPTH = 1 << copro_pkg::EXT_ASIZE;

   // 128K bytes behind the controller
   logic [7:0] mem [0:DEPTH-1];

   // power-up contents, every address bit folds in
   initial
   begin
      for (int i = 0; i < DEPTH; i++)
         mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'(i >> 16);
   end

   // byte lands at the end of the controller's byte cycle
   always @(posedge cpu_clk)
   begin
      if (!ram_cs_b && !ram_we_b)
         mem[ram_addr] <= ram_dout;
   end

   // flow-through read, pulled-up bus when not driven
   assign ram_din = (!ram_cs_b && !ram_oe_b) ? mem[ram_addr] : 8'hFF;

endmodule

`default_nettype wire

// File: copro_bus.sv
`default_nettype none

module copro_bus (
   input  wire                             cpu_clk,
   input  wire                             reset,
   // cpu bus
   input  wire  [copro_pkg::ASIZE-1:0]     cpu_addr,
   input  wire  [copro_pkg::DSIZE-1:0]     cpu_dout,
   input  wire                             cpu_rnw,
   input  wire                             vpa,
   input  wire                             vda,
   input  wire                             vio,
   output logic [copro_pkg::DSIZE-1:0]     cpu_din,
   output logic                            cpu_clken,
   output logic                            cpu_irq_b,
   // host port
   input  wire  [tube_pkg::TUBE_AW-1:0]    h_addr,
   input  wire                             h_cs_b,
   input  wire                             h_rdnw,
   input  wire  [tube_pkg::TUBE_DW-1:0]    h_din,
   output logic [tube_pkg::TUBE_DW-1:0]    h_dout,
   output logic                            h_irq_b,
   // external sram
   output logic [copro_pkg::EXT_ASIZE-1:0] ram_addr,
   output logic [7:0]                      ram_dout,
   input  wire  [7:0]                      ram_din,
   output logic                            ram_cs_b,
   output logic                            ram_oe_b,
   output logic                            ram_we_b
);

   copro_pkg::mem_region_e          region;
   logic                            tube_sel;
   logic                            int_sel;
   logic                            ext_sel;
   logic                            p_sel;
   logic                            int_we;
   logic [copro_pkg::RAMSIZE-1:0]   int_addr;
   logic [3:0]                      addr_top;
   logic [copro_pkg::DSIZE-1:0]     int_dout;
   logic [copro_pkg::DSIZE-1:0]     ext_dout;
   logic [tube_pkg::TUBE_DW-1:0]    p_dout;
   logic                            p_irq_b;

   // --------------------------------------------------
   // address decode
   // --------------------------------------------------

   assign addr_top = cpu_addr[copro_pkg::ASIZE-1 -: 4];

   // tube wins on vio, memory on vpa/vda
   always_comb
   begin
      region = copro_pkg::REGION_NONE;
      if (vio && cpu_addr[copro_pkg::ASIZE-1:3] == copro_pkg::TUBE_BASE[copro_pkg::ASIZE-1:3])
         region = copro_pkg::REGION_TUBE;
      else if (vpa || vda)
      begin
         // top and bottom 4K words are on chip
         if (addr_top == 4'h0 || addr_top == 4'hF)
            region = copro_pkg::REGION_INT;
         else
            region = copro_pkg::REGION_EXT;
      end
   end

   assign tube_sel = (region == copro_pkg::REGION_TUBE);
   assign int_sel  = (region == copro_pkg::REGION_INT);
   assign ext_sel  = (region == copro_pkg::REGION_EXT);

   // writes and side effects only on the completing edge
   assign p_sel    = tube_sel && cpu_clken;
   assign int_we   = int_sel && !cpu_rnw && cpu_clken;

   // fold F000-FFFF onto the upper half of the array
   assign int_addr = {cpu_addr[copro_pkg::ASIZE-1], cpu_addr[copro_pkg::RAMSIZE-2:0]};

   // --------------------------------------------------
   // targets
   // --------------------------------------------------

   int_ram u_int_ram (
      .cpu_clk (cpu_clk),
      .we      (int_we),
      .addr    (int_addr),
      .wdata   (cpu_dout),
      .rdata   (int_dout)
   );

   ext_mem_ctrl u_ext_mem_ctrl (
      .cpu_clk   (cpu_clk),
      .reset     (reset),
      .ext_sel   (ext_sel),
      .cpu_rnw   (cpu_rnw),
      .cpu_addr  (cpu_addr),
      .cpu_dout  (cpu_dout),
      .ram_din   (ram_din),
      .cpu_clken (cpu_clken),
      .ext_dout  (ext_dout),
      .ram_addr  (ram_addr),
      .ram_dout  (ram_dout),
      .ram_cs_b  (ram_cs_b),
      .ram_oe_b  (ram_oe_b),
      .ram_we_b  (ram_we_b)
   );

   tube_regs u_tube_regs (
      .cpu_clk (cpu_clk),
      .reset   (reset),
      .p_sel   (p_sel),
      .p_addr  (cpu_addr[tube_pkg::TUBE_AW-1:0]),
      .p_rnw   (cpu_rnw),
      .p_din   (cpu_dout[tube_pkg::TUBE_DW-1:0]),
      .p_dout  (p_dout),
      .p_irq_b (p_irq_b),
      .h_cs_b  (h_cs_b),
      .h_addr  (h_addr),
      .h_rdnw  (h_rdnw),
      .h_din   (h_din),
      .h_dout  (h_dout),
      .h_irq_b (h_irq_b)
   );

   // --------------------------------------------------
   // read mux and interrupt
   // --------------------------------------------------

   // tube byte zero extended
   assign cpu_din = tube_sel ? copro_pkg::DSIZE'(p_dout) :
                    int_sel  ? int_dout : ext_dout;

   // one flop into the cpu clock domain view
   always_ff @(posedge cpu_clk)
   begin
      if (reset)
         cpu_irq_b <= 1'b1;
      else
         cpu_irq_b <= p_irq_b;
   end

   a_one_target : assert property (
      @(posedge cpu_clk) disable iff (reset)
      $onehot0({tube_sel, int_sel, ext_sel})
   );

endmodule

`default_nettype wire

// File: tube_regs.sv
`default_nettype none

module tube_regs (
   input  wire                           cpu_clk,
   input  wire                           reset,
   // parasite side
   input  wire                           p_sel,
   input  wire  [tube_pkg::TUBE_AW-1:0]  p_addr,
   input  wire                           p_rnw,
   input  wire  [tube_pkg::TUBE_DW-1:0]  p_din,
   output logic [tube_pkg::TUBE_DW-1:0]  p_dout,
   output logic                          p_irq_b,
   // host side, sampled on cpu_clk
   input  wire                           h_cs_b,
   input  wire  [tube_pkg::TUBE_AW-1:0]  h_addr,
   input  wire                           h_rdnw,
   input  wire  [tube_pkg::TUBE_DW-1:0]  h_din,
   output logic [tube_pkg::TUBE_DW-1:0]  h_dout,
   output logic                          h_irq_b
);

   // host to parasite latch
   logic [tube_pkg::TUBE_DW-1:0] h2p_data;
   logic                         h2p_full;
   // parasite to host latch
   logic [tube_pkg::TUBE_DW-1:0] p2h_data;
   logic                         p2h_full;
   logic                         irq_en;
   logic [tube_pkg::TUBE_DW-1:0] ctrl_byte;
   // data register strobes
   logic                         p_rd_data;
   logic                         p_wr_data;
   logic                         h_rd_data;
   logic                         h_wr_data;
   logic                         h_wr_ctrl;
   // qualified latch events
   logic                         h2p_fill;
   logic                         h2p_drain;
   logic                         p2h_fill;
   logic                         p2h_drain;

   function automatic logic [tube_pkg::TUBE_DW-1:0] status_byte(input logic avail,
                                                                input logic room);
      logic [tube_pkg::TUBE_DW-1:0] s;
      s = '0;
      s[tube_pkg::STAT_AVAIL] = avail;
      s[tube_pkg::STAT_ROOM]  = room;
      return s;
   endfunction

   // --------------------------------------------------
   // access strobes
   // --------------------------------------------------

   assign p_rd_data = p_sel && p_rnw && (p_addr == tube_pkg::TUBE_DATA);
   assign p_wr_data = p_sel && !p_rnw && (p_addr == tube_pkg::TUBE_DATA);
   assign h_rd_data = !h_cs_b && h_rdnw && (h_addr == tube_pkg::TUBE_DATA);
   assign h_wr_data = !h_cs_b && !h_rdnw && (h_addr == tube_pkg::TUBE_DATA);
   assign h_wr_ctrl = !h_cs_b && !h_rdnw && (h_addr == tube_pkg::TUBE_CTRL);

   // write to a full latch is dropped
   assign h2p_fill  = h_wr_data && !h2p_full;
   assign h2p_drain = p_rd_data && h2p_full;
   assign p2h_fill  = p_wr_data && !p2h_full;
   assign p2h_drain = h_rd_data && p2h_full;

   // --------------------------------------------------
   // flags and control
   // --------------------------------------------------

   always_ff @(posedge cpu_clk)
   begin
      if (reset)
      begin
         h2p_full <= 1'b0;
         p2h_full <= 1'b0;
         irq_en   <= 1'b0;
      end
      else
      begin
         if (h2p_fill)
            h2p_full <= 1'b1;
         else if (h2p_drain)
            h2p_full <= 1'b0;
         if (p2h_fill)
            p2h_full <= 1'b1;
         else if (p2h_drain)
            p2h_full <= 1'b0;
         // enable only reachable from the host
         if (h_wr_ctrl)
            irq_en <= h_din[tube_pkg::CTRL_IRQ_EN];
      end
   end

   // latch payload
   always_ff @(posedge cpu_clk)
   begin
      if (h2p_fill)
         h2p_data <= h_din;
      if (p2h_fill)
         p2h_data <= p_din;
   end

   // --------------------------------------------------
   // read back
   // --------------------------------------------------

   assign ctrl_byte = tube_pkg::TUBE_DW'(irq_en) << tube_pkg::CTRL_IRQ_EN;

   // parasite view, avail = host byte waiting
   always_comb
   begin
      case (p_addr)
         tube_pkg::TUBE_STATUS: p_dout = status_byte(h2p_full, !p2h_full);
         tube_pkg::TUBE_DATA:   p_dout = h2p_data;
         tube_pkg::TUBE_CTRL:   p_dout = ctrl_byte;
         default:               p_dout = '0;
      endcase
   end

   // host view, mirror image
   always_comb
   begin
      case (h_addr)
         tube_pkg::TUBE_STATUS: h_dout = status_byte(p2h_full, !h2p_full);
         tube_pkg::TUBE_DATA:   h_dout = p2h_data;
         tube_pkg::TUBE_CTRL:   h_dout = ctrl_byte;
         default:               h_dout = '0;
      endcase
   end

   // interrupt parasite while host data waits
   assign p_irq_b = !(h2p_full && irq_en);
   // host irq pin kept, never asserted
   assign h_irq_b = 1'b1;

   // a latch fills only from its writer's side and empties only from its reader's side
   a_h2p_latch : assert property (
      @(posedge cpu_clk) disable iff (reset)
      (h2p_full != $past(h2p_full)) |-> (h2p_full ? $past(h_wr_data) : $past(p_rd_data))
   );

   a_p2h_latch : assert property (
      @(posedge cpu_clk) disable iff (reset)
      (p2h_full != $past(p2h_full)) |-> (p2h_full ? $past(p_wr_data) : $past(h_rd_data))
   );

endmodule

`default_nettype wire

// File: ext_mem_ctrl.sv
`default_nettype none

module ext_mem_ctrl (
   input  wire                             cpu_clk,
   input  wire                             reset,
   input  wire                             ext_sel,
   input  wire                             cpu_rnw,
   input  wire  [copro_pkg::ASIZE-1:0]     cpu_addr,
   input  wire  [copro_pkg::DSIZE-1:0]     cpu_dout,
   input  wire  [7:0]                      ram_din,
   output logic                            cpu_clken,
   output logic [copro_pkg::DSIZE-1:0]     ext_dout,
   output logic [copro_pkg::EXT_ASIZE-1:0] ram_addr,
   output logic [7:0]                      ram_dout,
   output logic                            ram_cs_b,
   output logic                            ram_oe_b,
   output logic                            ram_we_b
);

   // registered state, never holds EXT_LO
   copro_pkg::ext_state_e       state;
   // state the pins act on this cycle
   copro_pkg::ext_state_e       phase;
   logic [copro_pkg::ASIZE-1:0] word_addr;
   logic [copro_pkg::DSIZE-1:0] rd_word;
   logic                        byte_cycle;
   logic                        hi_byte;

   // --------------------------------------------------
   // sequencing
   // --------------------------------------------------

   // low byte goes out in the same cycle ext_sel shows up,
   // so idle plus select is the low byte cycle
   always_comb
   begin
      if (state == copro_pkg::EXT_IDLE && ext_sel)
         phase = copro_pkg::EXT_LO;
      else
         phase = state;
   end

   // lo -> hi -> done -> idle, three cycles per cpu access
   always_ff @(posedge cpu_clk)
   begin
      if (reset)
         state <= copro_pkg::EXT_IDLE;
      else
      begin
         case (phase)
            copro_pkg::EXT_LO:   state <= copro_pkg::EXT_HI;
            copro_pkg::EXT_HI:   state <= copro_pkg::EXT_DONE;
            // done ends the access, cpu moves on
            default:             state <= copro_pkg::EXT_IDLE;
         endcase
      end
   end

   assign byte_cycle = (phase == copro_pkg::EXT_LO) || (phase == copro_pkg::EXT_HI);
   assign hi_byte    = (phase == copro_pkg::EXT_HI);

   // stall while a byte cycle is running
   assign cpu_clken  = !byte_cycle;

   // --------------------------------------------------
   // sram pins
   // --------------------------------------------------

   // window starts at EXT_BASE, word 0 of the sram
   assign word_addr = cpu_addr - copro_pkg::EXT_BASE;
   // even byte first, odd byte second
   assign ram_addr  = {word_addr, hi_byte};

   assign ram_cs_b  = !byte_cycle;
   assign ram_oe_b  = !(byte_cycle && cpu_rnw);
   assign ram_we_b  = !(byte_cycle && !cpu_rnw);

   // little endian split of the cpu word
   assign ram_dout  = hi_byte ? cpu_dout[copro_pkg::DSIZE-1:8] : cpu_dout[7:0];

   // --------------------------------------------------
   // read assembly
   // --------------------------------------------------

   // capture each byte at the end of its cycle
   // word is complete by EXT_DONE
   always_ff @(posedge cpu_clk)
   begin
      if (cpu_rnw && phase == copro_pkg::EXT_LO)
         rd_word[7:0] <= ram_din;
      if (cpu_rnw && hi_byte)
         rd_word[copro_pkg::DSIZE-1:8] <= ram_din;
   end

   assign ext_dout = rd_word;

   // --------------------------------------------------
   // checks
   // --------------------------------------------------

   // sram bus contention
   a_oe_we_excl : assert property (
      @(posedge cpu_clk) disable iff (reset)
      !(!ram_we_b && !ram_oe_b)
   );

   // access length as the cpu sees it
   a_ext_len : assert property (
      @(posedge cpu_clk) disable iff (reset)
      (state == copro_pkg::EXT_IDLE && ext_sel) |-> ##2 (state == copro_pkg::EXT_DONE)
   );

endmodule

`default_nettype wire

// File: int_ram.sv
`default_nettype none

module int_ram (
   input  wire                           cpu_clk,
   input  wire                           we,
   input  wire  [copro_pkg::RAMSIZE-1:0] addr,
   input  wire  [copro_pkg::DSIZE-1:0]   wdata,
   output logic [copro_pkg::DSIZE-1:0]   rdata
);

   // --------------------------------------------------
   // storage
   // --------------------------------------------------

   // 8K words, no reset on the array
   logic [copro_pkg::DSIZE-1:0] mem [0:(1 << copro_pkg::RAMSIZE)-1];

   // write on the edge that completes the cpu cycle
   // caller already qualifies we with cpu_clken
   always_ff @(posedge cpu_clk)
   begin
      if (we)
         mem[addr] <= wdata;
   end

   // read data valid in the same cycle as the address
   assign rdata = mem[addr];

   // --------------------------------------------------
   // checks
   // --------------------------------------------------

   // decode upstream must hand over a clean index on writes
   a_wr_addr_known : assert property (
      @(posedge cpu_clk) we |-> !$isunknown(addr)
   );

endmodule

`default_nettype wire

// File: tube_pkg.sv
`default_nettype none

package tube_pkg;

   // mailbox is byte wide with three register address bits
   localparam int TUBE_DW = 8;
   localparam int TUBE_AW = 3;

   // register numbers, low address bits on either side
   typedef enum logic [TUBE_AW-1:0] {
      TUBE_STATUS = 3'd0,
      TUBE_DATA   = 3'd1,
      TUBE_CTRL   = 3'd2
   } tube_reg_e;

   // status bits, as seen by whichever side reads them
   // byte waiting for this side
   localparam int STAT_AVAIL  = 7;
   // other side's latch is empty
   localparam int STAT_ROOM   = 6;

   // control register, host writes only
   localparam int CTRL_IRQ_EN = 0;

endpackage

`default_nettype wire

// File: copro_pkg.sv
`default_nettype none

package copro_pkg;

   // --------------------------------------------------
   // cpu bus and memory map sizes
   // --------------------------------------------------

   // 16 bit parasite cpu
   localparam int DSIZE     = 16;
   localparam int ASIZE     = 16;

   // internal ram, 8K words at 0000-0FFF and F000-FFFF
   localparam int RAMSIZE   = 13;

   // external sram, word address plus byte select
   localparam int EXT_ASIZE = 17;
   // first cpu address mapped to the external window
   localparam logic [ASIZE-1:0] EXT_BASE  = 16'h1000;

   // eight mailbox registers from here, vio space
   localparam logic [ASIZE-1:0] TUBE_BASE = 16'hFEF8;

   // --------------------------------------------------
   // decoder result and controller states
   // --------------------------------------------------

   typedef enum logic [1:0] {
      REGION_NONE,
      REGION_TUBE,
      REGION_INT,
      REGION_EXT
   } mem_region_e;

   // idle, low byte, high byte, word ready
   typedef enum logic [1:0] {
      EXT_IDLE,
      EXT_LO,
      EXT_HI,
      EXT_DONE
   } ext_state_e;

endpackage

`default_nettype wire
